// ==== files.f ====
+incdir+include
rtl/core_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/issue_stage.sv
rtl/alu_pipe.sv
rtl/mem_pipe.sv
rtl/core_top.sv
test/core_tb.sv

// ==== include/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and instruction word width
`define XLEN 32

// architectural registers, r0 reads as zero
`define REG_COUNT 16

`define FQ_DEPTH 4      // fetch queue entries
`define DMEM_WORDS 64   // data memory, in words
`define RESET_PC 0      // first fetch word address

`endif

// ==== rtl/alu_pipe.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_pipe import pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       issue,
	input  micro_op_t  mop,
	output wb_t        wb
);
	wb_t s1;    // result after the first stage
	logic [`XLEN-1:0] opb, result;

	assign opb = mop.use_imm ? mop.imm : mop.src1_val;

	always_comb begin
		case (mop.alu_op)
			ALU_SUB: result = mop.src0_val - opb;
			ALU_AND: result = mop.src0_val & opb;
			ALU_XOR: result = mop.src0_val ^ opb;
			default: result = mop.src0_val + opb;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1 <= '0;
			wb <= '0;
		end else begin
			s1.valid <= issue && mop.rd != '0;    // writes to r0 are dropped
			s1.rd <= mop.rd;
			s1.value <= result;
			wb <= s1;
		end
	end

endmodule

// ==== rtl/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_LD   = 4'd6,
		OP_ST   = 4'd7,
		OP_BEQZ = 4'd8
	} opcode_e;

	// register form, low half unused
	typedef struct packed {
		opcode_e         opcode;
		reg_idx_t        rd;
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		logic [15:0]     unused;
	} r_form_t;

	// immediate form, ST takes its data register from rd
	typedef struct packed {
		opcode_e            opcode;
		reg_idx_t           rd;
		reg_idx_t           rs1;
		logic [3:0]         spare;
		logic signed [15:0] imm;    // word offset for BEQZ
	} i_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_u;

endpackage

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top import core_pkg::*, pipe_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              imem_ack,
	input  instr_u            imem_data,
	output logic              imem_req,
	output logic [`XLEN-1:0]  imem_addr,
	output wb_t               alu_retire,
	output wb_t               mem_retire
);
	logic f_valid, f_ready;
	instr_u f_instr;
	logic [`XLEN-1:0] f_pc;
	logic d_valid, d_ready;
	micro_op_t d_mop;
	logic alu_issue, mem_issue, mem_busy;
	micro_op_t alu_mop, mem_mop;
	wb_t alu_wb, mem_wb;
	logic redirect;
	logic [`XLEN-1:0] redirect_pc;

	fetch_unit fetch_inst (
		.clk, .reset, .imem_ack, .imem_data, .redirect, .redirect_pc,
		.out_ready(f_ready), .imem_req, .imem_addr,
		.out_valid(f_valid), .out_instr(f_instr), .out_pc(f_pc)
	);

	decode_stage decode_inst (
		.clk, .reset, .in_valid(f_valid), .in_instr(f_instr), .in_pc(f_pc),
		.redirect, .out_ready(d_ready), .in_ready(f_ready),
		.out_valid(d_valid), .out_mop(d_mop)
	);

	issue_stage issue_inst (
		.clk, .reset, .in_valid(d_valid), .in_mop(d_mop), .mem_busy, .alu_wb, .mem_wb,
		.in_ready(d_ready), .alu_issue, .alu_mop, .mem_issue, .mem_mop,
		.redirect, .redirect_pc
	);

	alu_pipe alu_inst (.clk, .reset, .issue(alu_issue), .mop(alu_mop), .wb(alu_wb));

	mem_pipe mem_inst (
		.clk, .reset, .issue(mem_issue), .mop(mem_mop), .busy(mem_busy), .wb(mem_wb)
	);

	assign alu_retire = alu_wb;
	assign mem_retire = mem_wb;

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage import core_pkg::*, pipe_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  instr_u            in_instr,
	input  logic [`XLEN-1:0]  in_pc,
	input  logic              redirect,
	input  logic              out_ready,
	output logic              in_ready,
	output logic              out_valid,
	output micro_op_t         out_mop
);
	micro_op_t dec;
	logic dec_valid;
	logic accept;

	always_comb begin
		dec = '0;
		dec_valid = 1'b1;
		dec.pc = in_pc;
		dec.imm = {{(`XLEN-16){in_instr.i_form.imm[15]}}, in_instr.i_form.imm};
		case (in_instr.r_form.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				dec.kind = UOP_ALU;
				dec.rd = in_instr.r_form.rd;
				dec.rs1 = in_instr.r_form.rs1;
				dec.rs2 = in_instr.r_form.rs2;
				case (in_instr.r_form.opcode)
					OP_SUB:  dec.alu_op = ALU_SUB;
					OP_AND:  dec.alu_op = ALU_AND;
					OP_XOR:  dec.alu_op = ALU_XOR;
					default: dec.alu_op = ALU_ADD;
				endcase
			end
			OP_ADDI: begin
				dec.kind = UOP_ALU;
				dec.alu_op = ALU_ADD;
				dec.rd = in_instr.i_form.rd;
				dec.rs1 = in_instr.i_form.rs1;
				dec.use_imm = 1'b1;
			end
			OP_LD: begin
				dec.kind = UOP_MEM;
				dec.rd = in_instr.i_form.rd;
				dec.rs1 = in_instr.i_form.rs1;
				dec.use_imm = 1'b1;
			end
			OP_ST: begin
				dec.kind = UOP_MEM;
				dec.is_store = 1'b1;
				dec.rs1 = in_instr.i_form.rs1;
				dec.rs2 = in_instr.i_form.rd;    // data source, no destination
				dec.use_imm = 1'b1;
			end
			OP_BEQZ: begin
				dec.kind = UOP_BRANCH;
				dec.rs1 = in_instr.i_form.rs1;
			end
			default: dec_valid = 1'b0;    // nop and spare opcodes vanish here
		endcase
	end

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready && !redirect;

	always_ff @(posedge clk) begin
		if (reset || redirect)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid && dec_valid;
	end

	always_ff @(posedge clk) begin
		if (accept)
			out_mop <= dec;
	end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_unit import core_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              imem_ack,
	input  instr_u            imem_data,
	input  logic              redirect,
	input  logic [`XLEN-1:0]  redirect_pc,
	input  logic              out_ready,
	output logic              imem_req,
	output logic [`XLEN-1:0]  imem_addr,
	output logic              out_valid,
	output instr_u            out_instr,
	output logic [`XLEN-1:0]  out_pc
);
	localparam int PW = $clog2(`FQ_DEPTH);
	localparam int CW = $clog2(`FQ_DEPTH + 1);

	typedef struct packed {
		instr_u            instr;
		logic [`XLEN-1:0]  pc;
	} fq_entry_t;

	fq_entry_t fq_mem [`FQ_DEPTH];
	logic [PW-1:0] head, tail;
	logic [CW-1:0] count;
	logic [`XLEN-1:0] fetch_pc;
	logic discard;    // open request is older than a redirect
	logic start, capture, push, pop;

	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		return (p == PW'(`FQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// a new request needs an idle handshake and a free slot
	assign start = !imem_req && !imem_ack && !redirect && (count < CW'(`FQ_DEPTH));
	assign capture = imem_req && imem_ack;
	assign push = capture && !discard && !redirect;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			imem_req <= 1'b0;
			imem_addr <= `XLEN'(`RESET_PC);
			fetch_pc <= `XLEN'(`RESET_PC);
			discard <= 1'b0;
		end else begin
			if (start) begin
				imem_req <= 1'b1;
				imem_addr <= fetch_pc;    // held until the word comes back
				fetch_pc <= fetch_pc + 1'b1;
			end else if (capture) begin
				imem_req <= 1'b0;
			end
			if (capture)
				discard <= 1'b0;
			else if (redirect && imem_req)
				discard <= 1'b1;
			if (redirect)
				fetch_pc <= redirect_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= ptr_inc(tail);
			if (pop)
				head <= ptr_inc(head);
			count <= count + CW'(push) - CW'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			fq_mem[tail] <= '{instr: imem_data, pc: imem_addr};
	end

	assign out_valid = count != '0;
	assign out_instr = fq_mem[head].instr;
	assign out_pc = fq_mem[head].pc;

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module issue_stage import pipe_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  micro_op_t         in_mop,
	input  logic              mem_busy,
	input  wb_t               alu_wb,
	input  wb_t               mem_wb,
	output logic              in_ready,
	output logic              alu_issue,
	output micro_op_t         alu_mop,
	output logic              mem_issue,
	output micro_op_t         mem_mop,
	output logic              redirect,
	output logic [`XLEN-1:0]  redirect_pc
);
	logic [`XLEN-1:0] reg_file [`REG_COUNT];
	logic [`REG_COUNT-1:0] sb;    // one pending bit per register
	logic [`REG_COUNT-1:0] sb_set, sb_clr;
	micro_op_t mop;
	logic hazard, dispatch;

	// operand read
	always_comb begin
		mop = in_mop;
		mop.src0_val = reg_file[in_mop.rs1];
		mop.src1_val = reg_file[in_mop.rs2];
	end

	// unused source fields decode to r0, which is never pending
	assign hazard = sb[in_mop.rs1] || sb[in_mop.rs2] || sb[in_mop.rd];
	assign in_ready = !hazard && !(in_mop.kind == UOP_MEM && mem_busy);
	assign dispatch = in_valid && in_ready;

	assign alu_issue = dispatch && in_mop.kind == UOP_ALU;
	assign mem_issue = dispatch && in_mop.kind == UOP_MEM;
	assign alu_mop = mop;
	assign mem_mop = mop;

	// beqz is resolved here and never reaches a pipe
	assign redirect = dispatch && in_mop.kind == UOP_BRANCH && mop.src0_val == '0;
	assign redirect_pc = in_mop.pc + in_mop.imm;

	always_comb begin
		sb_set = '0;
		sb_clr = '0;
		if (dispatch && in_mop.kind != UOP_BRANCH && in_mop.rd != '0)
			sb_set[in_mop.rd] = 1'b1;
		if (alu_wb.valid)
			sb_clr[alu_wb.rd] = 1'b1;
		if (mem_wb.valid)
			sb_clr[mem_wb.rd] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sb <= '0;
		else
			sb <= (sb & ~sb_clr) | sb_set;
	end

	// both pipes may write back together, the scoreboard keeps their rd apart
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				reg_file[i] <= '0;
		end else begin
			if (alu_wb.valid && alu_wb.rd != '0)
				reg_file[alu_wb.rd] <= alu_wb.value;
			if (mem_wb.valid && mem_wb.rd != '0)
				reg_file[mem_wb.rd] <= mem_wb.value;
		end
	end

endmodule

// ==== rtl/mem_pipe.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module mem_pipe import pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       issue,
	input  micro_op_t  mop,
	output logic       busy,
	output wb_t        wb
);
	localparam int AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];
	micro_op_t op_q;
	logic [1:0] phase;    // 0 idle, 1 address, 2 access
	logic [AW-1:0] addr_q;
	logic [`XLEN-1:0] ea;

	assign busy = phase != 2'd0;
	assign ea = op_q.src0_val + op_q.imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 2'd0;
		end else begin
			case (phase)
				2'd0:    phase <= issue ? 2'd1 : 2'd0;
				2'd1:    phase <= 2'd2;
				default: phase <= 2'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == 2'd0 && issue)
			op_q <= mop;
		if (phase == 2'd1)
			addr_q <= AW'(ea % `DMEM_WORDS);    // word address wraps
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (phase == 2'd2 && op_q.is_store) begin
			dmem[addr_q] <= op_q.src1_val;
		end
	end

	// load data leaves in the access cycle
	always_comb begin
		wb.valid = phase == 2'd2 && !op_q.is_store && op_q.rd != '0;
		wb.rd = op_q.rd;
		wb.value = dmem[addr_q];
	end

endmodule

// ==== rtl/pipe_pkg.sv ====
`include "core_cfg.svh"

package pipe_pkg;

	import core_pkg::*;

	typedef enum logic [1:0] {UOP_ALU, UOP_MEM, UOP_BRANCH} uop_kind_e;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_e;

	typedef struct packed {
		uop_kind_e         kind;
		alu_op_e           alu_op;
		logic              is_store;
		reg_idx_t          rd;
		reg_idx_t          rs1;
		reg_idx_t          rs2;         // store data register for ST
		logic              use_imm;
		logic [`XLEN-1:0]  imm;         // already sign extended
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  src0_val;    // operands, filled at issue
		logic [`XLEN-1:0]  src1_val;
	} micro_op_t;

	typedef struct packed {
		logic              valid;
		reg_idx_t          rd;
		logic [`XLEN-1:0]  value;
	} wb_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module core_tb -f files.f -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -x "Simulation PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== test/core_tb.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb import core_pkg::*, pipe_pkg::*; ();
	localparam int PROG_WORDS = 32;
	localparam int MAX_WB = 32;         // expected write-backs kept per register
	localparam int WAIT_LIMIT = 2000;
	localparam int DRAIN_CYCLES = 20;
	localparam int TEST_COUNT = 4;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic imem_ack = 1'b0;
	instr_u imem_data = '0;
	logic imem_req;
	logic [`XLEN-1:0] imem_addr;
	wb_t alu_retire, mem_retire;

	instr_u prog [PROG_WORDS];
	int prog_len;
	logic [`XLEN-1:0] exp_vals [`REG_COUNT][MAX_WB];
	int exp_cnt [`REG_COUNT];
	int exp_total;
	int seen [`REG_COUNT];    // write-backs retired so far, per register
	int wb_total;
	int errors = 0;
	logic [31:0] lcg_state = 32'h39ea;
	logic [1:0] ack_delay;
	logic alu_exp_ok, mem_exp_ok;    // another write-back is due for that register
	logic [`XLEN-1:0] alu_exp, mem_exp;

	core_top core_top_inst (
		.clk, .reset, .imem_ack, .imem_data, .imem_req, .imem_addr, .alu_retire, .mem_retire
	);

	initial begin
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic instr_u word_at(input logic [`XLEN-1:0] addr);
		if (addr < PROG_WORDS)
			return prog[addr[$clog2(PROG_WORDS)-1:0]];
		return '0;    // nop past the program
	endfunction

	function automatic instr_u reg_word(input opcode_e op, input int rd, input int rs1,
			input int rs2);
		instr_u w;
		w = '0;
		w.r_form.opcode = op;
		w.r_form.rd = reg_idx_t'(rd);
		w.r_form.rs1 = reg_idx_t'(rs1);
		w.r_form.rs2 = reg_idx_t'(rs2);
		return w;
	endfunction

	function automatic instr_u imm_word(input opcode_e op, input int rd, input int rs1,
			input int imm);
		instr_u w;
		w = '0;
		w.i_form.opcode = op;
		w.i_form.rd = reg_idx_t'(rd);
		w.i_form.rs1 = reg_idx_t'(rs1);
		w.i_form.imm = 16'(imm);
		return w;
	endfunction

	task automatic emit(input instr_u w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic report_retire(input string port, input reg_idx_t rd,
			input logic [`XLEN-1:0] value, input logic due, input logic [`XLEN-1:0] expected);
		if (due)
			$display("ERR at %0t ns: %s retire r%0d = %h, expected %h",
				$time, port, rd, value, expected);
		else
			$display("ERR at %0t ns: %s retire r%0d = %h, no further write-back expected",
				$time, port, rd, value);
		errors++;
	endtask

	task automatic report_protocol(input string what);
		$display("protocol error at %0t ns: %s", $time, what);
		errors++;
	endtask

	// four-phase responder, 0 to 3 idle cycles before each ack edge
	always @(posedge clk) begin
		if (reset) begin
			imem_ack <= 1'b0;
			ack_delay <= lcg_state[17:16];
			lcg_state <= lcg_next(lcg_state);
		end else if (imem_req != imem_ack) begin
			if (ack_delay == 2'd0) begin
				imem_ack <= imem_req;
				if (imem_req)
					imem_data <= word_at(imem_addr);
				ack_delay <= lcg_state[17:16];
				lcg_state <= lcg_next(lcg_state);
			end else begin
				ack_delay <= ack_delay - 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < `REG_COUNT; r++)
				seen[r] <= 0;
			wb_total <= 0;
		end else begin
			if (alu_retire.valid)
				seen[alu_retire.rd] <= seen[alu_retire.rd] + 1;
			if (mem_retire.valid)
				seen[mem_retire.rd] <= seen[mem_retire.rd] + 1;
			wb_total <= wb_total + int'(alu_retire.valid) + int'(mem_retire.valid);
		end
	end

	// next value the model has for the register on each retire port
	always_comb begin
		alu_exp_ok = seen[alu_retire.rd] < exp_cnt[alu_retire.rd];
		alu_exp = alu_exp_ok ? exp_vals[alu_retire.rd][seen[alu_retire.rd]] : '0;
		mem_exp_ok = seen[mem_retire.rd] < exp_cnt[mem_retire.rd];
		mem_exp = mem_exp_ok ? exp_vals[mem_retire.rd][seen[mem_retire.rd]] : '0;
	end

	alu_value_check: assert property (@(posedge clk) disable iff (reset)
		alu_retire.valid |-> alu_exp_ok && alu_retire.value == alu_exp)
		else report_retire("alu", $sampled(alu_retire.rd), $sampled(alu_retire.value),
			$sampled(alu_exp_ok), $sampled(alu_exp));

	mem_value_check: assert property (@(posedge clk) disable iff (reset)
		mem_retire.valid |-> mem_exp_ok && mem_retire.value == mem_exp)
		else report_retire("mem", $sampled(mem_retire.rd), $sampled(mem_retire.value),
			$sampled(mem_exp_ok), $sampled(mem_exp));

	r0_check: assert property (@(posedge clk) disable iff (reset)
		!(alu_retire.valid && alu_retire.rd == '0) && !(mem_retire.valid && mem_retire.rd == '0))
		else report_protocol("a write-back to r0 appeared on a retire port");

	addr_stable_check: assert property (@(posedge clk) disable iff (reset)
		$past(imem_req) && imem_req |-> imem_addr == $past(imem_addr))
		else report_protocol("imem_addr changed while imem_req was held high");

	req_rise_check: assert property (@(posedge clk) disable iff (reset)
		!$past(imem_req) && imem_req |-> !$past(imem_ack))
		else report_protocol("imem_req rose while imem_ack was still high");

	reset_quiet_check: assert property (@(posedge clk)
		$past(reset) |-> !alu_retire.valid && !mem_retire.valid)
		else report_protocol("a retire port was valid during or right after reset");

	// sequential execution of the program, one instruction at a time
	task automatic run_model();
		logic [`XLEN-1:0] regs [`REG_COUNT];
		logic [`XLEN-1:0] data [`DMEM_WORDS];
		logic [`XLEN-1:0] pc, next_pc, a, b, imm, res;
		instr_u w;
		int steps;
		for (int r = 0; r < `REG_COUNT; r++) begin
			regs[r] = '0;
			exp_cnt[r] = 0;
		end
		for (int m = 0; m < `DMEM_WORDS; m++)
			data[m] = '0;
		exp_total = 0;
		pc = '0;
		steps = 0;
		while (pc < prog_len && steps < 500) begin
			w = prog[pc];
			a = regs[w.i_form.rs1];
			b = regs[w.r_form.rs2];
			imm = {{(`XLEN-16){w.i_form.imm[15]}}, w.i_form.imm};
			next_pc = pc + 1;
			res = '0;
			case (w.r_form.opcode)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_XOR:  res = a ^ b;
				OP_ADDI: res = a + imm;
				OP_LD:   res = data[(a + imm) % `DMEM_WORDS];
				OP_ST:   data[(a + imm) % `DMEM_WORDS] = regs[w.i_form.rd];
				OP_BEQZ: next_pc = (a == '0) ? pc + imm : pc + 1;
				default: ;
			endcase
			if (w.r_form.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD} &&
					w.r_form.rd != '0) begin
				regs[w.r_form.rd] = res;
				exp_vals[w.r_form.rd][exp_cnt[w.r_form.rd]] = res;
				exp_cnt[w.r_form.rd]++;
				exp_total++;
			end
			pc = next_pc;
			steps++;
		end
	endtask

	task automatic load_alu_prog();
		emit(imm_word(OP_ADDI, 1, 0, 5));
		emit(imm_word(OP_ADDI, 2, 0, -3));
		emit(reg_word(OP_ADD, 3, 1, 2));
		emit(reg_word(OP_SUB, 4, 1, 2));
		emit(reg_word(OP_AND, 5, 1, 2));
		emit(reg_word(OP_XOR, 6, 1, 2));
		emit(imm_word(OP_NOP, 0, 0, 0));
		emit(imm_word(OP_ADDI, 7, 6, -100));
		emit(reg_word(OP_ADD, 0, 1, 1));    // r0 stays zero
		emit(reg_word(OP_SUB, 8, 0, 7));
	endtask

	task automatic load_dep_prog();
		emit(imm_word(OP_ADDI, 1, 0, 1));
		emit(reg_word(OP_ADD, 1, 1, 1));
		emit(reg_word(OP_ADD, 1, 1, 1));
		emit(imm_word(OP_ADDI, 1, 1, -7));
		emit(reg_word(OP_XOR, 2, 1, 1));
		emit(imm_word(OP_ADDI, 2, 2, 9));
		emit(imm_word(OP_ST, 2, 0, 4));
		emit(imm_word(OP_LD, 3, 0, 4));
		emit(imm_word(OP_ADDI, 3, 3, 1));    // load result used right away
		emit(reg_word(OP_SUB, 3, 3, 1));
	endtask

	task automatic load_mem_prog();
		emit(imm_word(OP_ADDI, 1, 0, 'h123));
		emit(imm_word(OP_ADDI, 2, 0, 10));
		emit(imm_word(OP_ST, 1, 2, 3));
		emit(imm_word(OP_LD, 3, 2, 3));
		emit(imm_word(OP_LD, 0, 2, 3));     // load into r0 is dropped
		emit(imm_word(OP_LD, 4, 0, 40));    // never written
		emit(imm_word(OP_ADDI, 5, 0, -1));
		emit(imm_word(OP_ST, 5, 2, -12));   // wraps to word 62
		emit(imm_word(OP_LD, 6, 0, 62));
		emit(imm_word(OP_ST, 3, 0, 5));
		emit(imm_word(OP_ST, 4, 0, 5));
		emit(imm_word(OP_LD, 7, 0, 5));
	endtask

	task automatic load_branch_prog();
		emit(imm_word(OP_ADDI, 1, 0, 0));
		emit(imm_word(OP_BEQZ, 0, 1, 3));     // taken, skips the next two
		emit(imm_word(OP_ADDI, 2, 0, 111));
		emit(imm_word(OP_ADDI, 3, 0, 222));
		emit(imm_word(OP_ADDI, 4, 0, 7));
		emit(imm_word(OP_BEQZ, 0, 4, 5));     // falls through
		emit(imm_word(OP_ADDI, 5, 4, 1));
		emit(imm_word(OP_ADDI, 6, 0, 3));
		emit(imm_word(OP_ADDI, 6, 6, -1));    // loop body
		emit(imm_word(OP_ADDI, 7, 7, 2));
		emit(imm_word(OP_BEQZ, 0, 6, 2));
		emit(imm_word(OP_BEQZ, 0, 0, -3));    // back to the loop body
		emit(imm_word(OP_ADDI, 8, 7, 0));
	endtask

	task automatic run_test(input int id, output logic ok);
		int errs_before;
		int cycles;
		string name;
		errs_before = errors;
		reset <= 1'b1;
		@(posedge clk);    // reset now seen by the checks, program can be swapped
		for (int a = 0; a < PROG_WORDS; a++)
			prog[a] = '0;
		prog_len = 0;
		case (id)
			1: begin
				name = "alu results";
				load_alu_prog();
			end
			2: begin
				name = "dependences";
				load_dep_prog();
			end
			3: begin
				name = "loads and stores";
				load_mem_prog();
			end
			default: begin
				name = "branches";
				load_branch_prog();
			end
		endcase
		run_model();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (wb_total < exp_total && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (wb_total < exp_total) begin
			$display("test %0d (%s) timed out: only %0d of %0d write-backs after %0d cycles",
				id, name, wb_total, exp_total, cycles);
			errors++;
		end
		// late write-backs from skipped instructions would show up here
		repeat (DRAIN_CYCLES) @(posedge clk);
		assert (wb_total == exp_total)
		else begin
			$display("ERR at %0t ns: %0d write-backs, expected %0d", $time, wb_total, exp_total);
			errors++;
		end
		for (int r = 1; r < `REG_COUNT; r++) begin
			assert (seen[r] == exp_cnt[r])
			else begin
				$display("ERR at %0t ns: r%0d retired %0d times, expected %0d",
					$time, r, seen[r], exp_cnt[r]);
				errors++;
			end
		end
		ok = errors == errs_before;
		$display("test %0d (%s): %s", id, name, ok ? "pass" : "fail");
	endtask

	initial begin
		logic ok;
		int passed;
		passed = 0;
		for (int id = 1; id <= TEST_COUNT; id++) begin
			run_test(id, ok);
			if (ok)
				passed++;
		end
		$display("tests: %0d run, %0d passed, %0d failed, %0d errors",
			TEST_COUNT, passed, TEST_COUNT - passed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
